//--- Bender.yml
package:
  name: conv_layer

sources:
  - files:
      - common/conv_geom_pkg.sv
      - common/conv_stream_pkg.sv
      - hw/conv_layer/conv_sequencer.sv
      - hw/conv_layer/operand_fetch.sv
      - hw/conv_layer/tap_emitter.sv
      - hw/conv_layer/result_writeback.sv
      - hw/conv_layer/conv_layer_top.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/conv_layer_properties.sv
      - sim/conv_layer_tb.sv

//--- common/conv_geom_pkg.sv
// Image, block and filter geometry of the first conv layer
// Address and loop index types
package conv_geom_pkg;

    localparam int IMG_WIDTH          = 8;
    localparam int IMG_HEIGHT         = 8;
    localparam int IMG_QUADS_PER_ROW  = IMG_WIDTH / 2;
    localparam int BLOCKS_PER_ROW     = (IMG_WIDTH - 2) / 2;   // Stride of 2 pixels
    localparam int BLOCKS_PER_COL     = (IMG_HEIGHT - 2) / 2;
    localparam int NUM_BLOCKS         = BLOCKS_PER_ROW * BLOCKS_PER_COL;
    localparam int NUM_FILTERS        = 4;
    localparam int KERNEL_DIM         = 3;
    localparam int BLOCK_DIM          = KERNEL_DIM + 1;        // 2x2 outputs per block
    localparam int BLOCK_PIXELS       = BLOCK_DIM * BLOCK_DIM;
    localparam int TAPS               = KERNEL_DIM * KERNEL_DIM;
    localparam int WEIGHTS_PER_FILTER = TAPS + 1;              // Bias first
    localparam int NUM_RESULTS        = NUM_FILTERS * NUM_BLOCKS;

    typedef logic [7:0] pixel_t;

    // One quad per bank word, four banks
    typedef logic [$clog2(IMG_QUADS_PER_ROW * IMG_HEIGHT / 2)-1:0] quad_addr_t;
    typedef logic [$clog2(NUM_FILTERS * WEIGHTS_PER_FILTER)-1:0] weight_addr_t;
    typedef logic [$clog2((NUM_RESULTS + 3) / 4)-1:0] res_addr_t;

    typedef logic [$clog2(NUM_BLOCKS)-1:0] block_idx_t;
    typedef logic [$clog2(NUM_FILTERS)-1:0] filter_idx_t;
    typedef logic [$clog2(NUM_RESULTS + 1)-1:0] result_idx_t;

endpackage

//--- common/conv_stream_pkg.sv
// MAC beat stream, post-op and operand bundle types
// Residue bank write port type
package conv_stream_pkg;

    import conv_geom_pkg::*;

    // Header + taps + post-op
    localparam int BEATS_PER_BLOCK = TAPS + 2;

    // Pixel of bank b sits in bank[b]
    typedef struct packed {
        pixel_t [3:0] bank;
    } quad_t;

    typedef struct packed {
        logic       maxpool;
        logic       relu;
        logic [5:0] shift;
    } post_op_t;

    // Lane 0 is a pixel on tap beats, the post-op word on the post beat
    typedef union packed {
        pixel_t   px;
        post_op_t op;
    } lane0_u;

    typedef enum logic [1:0] {
        BEAT_HEADER,
        BEAT_TAP,
        BEAT_POST
    } beat_kind_t;

    typedef struct packed {
        beat_kind_t kind;
        lane0_u     lane0;
        pixel_t     lane1;
        pixel_t     lane2;
        pixel_t     lane3;
        pixel_t     param;
    } mac_beat_t;

    typedef struct packed {
        pixel_t [BLOCK_PIXELS-1:0]       block;      // Row-major 4x4
        pixel_t [WEIGHTS_PER_FILTER-1:0] weights;    // [0] is the bias
        filter_idx_t                     filter_idx;
        post_op_t                        post_op;
    } operand_t;

    typedef struct packed {
        logic       en;
        logic [1:0] bank;
        res_addr_t  addr;
        pixel_t     data;
    } res_write_t;

endpackage

//--- conv_layer.f
common/conv_geom_pkg.sv
common/conv_stream_pkg.sv
hw/conv_layer/conv_sequencer.sv
hw/conv_layer/operand_fetch.sv
hw/conv_layer/tap_emitter.sv
hw/conv_layer/result_writeback.sv
hw/conv_layer/conv_layer_top.sv
sim/tb_clock_gen.sv
sim/conv_layer_properties.sv
sim/conv_layer_tb.sv

//--- hw/conv_layer/conv_layer_top.sv
// First-layer convolution sequencer top level
// Sequencer, operand fetch, beat emitter and residue write-back
`timescale 1ns/100ps

module conv_layer_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  conv_stream_pkg::post_op_t   post_op,
    output conv_geom_pkg::quad_addr_t   image_addr,
    input  conv_stream_pkg::quad_t      image_rd_data,
    output conv_geom_pkg::weight_addr_t weight_addr,
    input  conv_geom_pkg::pixel_t       weight_rd_data,
    output conv_stream_pkg::mac_beat_t  beat_out,
    output logic                        beat_valid,
    input  logic                        beat_ready,
    input  logic                        result_valid,
    input  conv_geom_pkg::pixel_t       result_data,
    output conv_stream_pkg::res_write_t res_write,
    output logic                        busy,
    output logic                        done
);

    import conv_geom_pkg::*;
    import conv_stream_pkg::*;

    logic        fetch_valid;
    logic        fetch_ready;
    block_idx_t  fetch_block;
    filter_idx_t fetch_filter;
    logic        fetch_load_weights;
    post_op_t    fetch_post_op;
    operand_t    opnd;
    logic        opnd_valid;
    logic        opnd_ready;
    logic        all_written;

    conv_sequencer u_sequencer (
        .clk                (clk),
        .reset              (reset),
        .start              (start),
        .post_op            (post_op),
        .fetch_valid        (fetch_valid),
        .fetch_ready        (fetch_ready),
        .fetch_block        (fetch_block),
        .fetch_filter       (fetch_filter),
        .fetch_load_weights (fetch_load_weights),
        .fetch_post_op      (fetch_post_op),
        .all_written        (all_written),
        .busy               (busy),
        .done               (done)
    );

    operand_fetch u_fetch (
        .clk                (clk),
        .reset              (reset),
        .fetch_valid        (fetch_valid),
        .fetch_ready        (fetch_ready),
        .fetch_block        (fetch_block),
        .fetch_filter       (fetch_filter),
        .fetch_load_weights (fetch_load_weights),
        .fetch_post_op      (fetch_post_op),
        .image_addr         (image_addr),
        .image_rd_data      (image_rd_data),
        .weight_addr        (weight_addr),
        .weight_rd_data     (weight_rd_data),
        .opnd               (opnd),
        .opnd_valid         (opnd_valid),
        .opnd_ready         (opnd_ready)
    );

    tap_emitter u_emitter (
        .clk        (clk),
        .reset      (reset),
        .opnd       (opnd),
        .opnd_valid (opnd_valid),
        .opnd_ready (opnd_ready),
        .beat_out   (beat_out),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    // Count restarts only on an accepted start
    result_writeback u_writeback (
        .clk          (clk),
        .reset        (reset),
        .start        (start && !busy),
        .result_valid (result_valid),
        .result_data  (result_data),
        .res_write    (res_write),
        .all_written  (all_written)
    );

endmodule

//--- hw/conv_layer/conv_sequencer.sv
// Filter and block loop control for the first conv layer
// Start, busy and done handling
`timescale 1ns/100ps

module conv_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  conv_stream_pkg::post_op_t  post_op,
    output logic                       fetch_valid,
    input  logic                       fetch_ready,
    output conv_geom_pkg::block_idx_t  fetch_block,
    output conv_geom_pkg::filter_idx_t fetch_filter,
    output logic                       fetch_load_weights,
    output conv_stream_pkg::post_op_t  fetch_post_op,
    input  logic                       all_written,
    output logic                       busy,
    output logic                       done
);

    import conv_geom_pkg::*;
    import conv_stream_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } state_t;

    state_t      state;
    block_idx_t  block_cnt;
    filter_idx_t filter_cnt;
    post_op_t    post_op_q;
    logic        last_block;
    logic        last_filter;

    assign last_block  = (block_cnt == block_idx_t'(NUM_BLOCKS - 1));
    assign last_filter = (filter_cnt == filter_idx_t'(NUM_FILTERS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            block_cnt  <= '0;
            filter_cnt <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= ISSUE;
                        block_cnt  <= '0;
                        filter_cnt <= '0;
                    end
                end
                ISSUE: begin
                    if (fetch_ready) begin   // Request taken this cycle
                        if (last_block) begin
                            block_cnt <= '0;
                            if (last_filter)
                                state <= DRAIN;
                            else
                                filter_cnt <= filter_cnt + 1'b1;
                        end else begin
                            block_cnt <= block_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // Wait for the last residue write
                    if (all_written) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start)
            post_op_q <= post_op;
    end

    assign busy               = (state != IDLE);
    assign fetch_valid        = (state == ISSUE);
    assign fetch_block        = block_cnt;
    assign fetch_filter       = filter_cnt;
    assign fetch_load_weights = (block_cnt == '0);   // New filter, new weights
    assign fetch_post_op      = post_op_q;

endmodule

//--- hw/conv_layer/operand_fetch.sv
// Weight-set load and 4x4 block fetch from the four image banks
// Builds one operand bundle per request
`timescale 1ns/100ps

module operand_fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fetch_valid,
    output logic                        fetch_ready,
    input  conv_geom_pkg::block_idx_t   fetch_block,
    input  conv_geom_pkg::filter_idx_t  fetch_filter,
    input  logic                        fetch_load_weights,
    input  conv_stream_pkg::post_op_t   fetch_post_op,
    output conv_geom_pkg::quad_addr_t   image_addr,
    input  conv_stream_pkg::quad_t      image_rd_data,
    output conv_geom_pkg::weight_addr_t weight_addr,
    input  conv_geom_pkg::pixel_t       weight_rd_data,
    output conv_stream_pkg::operand_t   opnd,
    output logic                        opnd_valid,
    input  logic                        opnd_ready
);

    import conv_geom_pkg::*;
    import conv_stream_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_W,
        FETCH_B,
        HOLD
    } state_t;

    state_t                          state;
    logic [3:0]                      step;
    quad_addr_t                      quad_base;
    weight_addr_t                    weight_base;
    filter_idx_t                     filter_q;
    post_op_t                        post_op_q;
    pixel_t [WEIGHTS_PER_FILTER-1:0] weight_buf;   // Kept across blocks of a filter
    pixel_t [BLOCK_PIXELS-1:0]       block_buf;
    logic [3:0]                      w_sel;
    logic [1:0]                      q_sel;
    logic [1:0]                      q_cap;

    assign fetch_ready = (state == IDLE);
    assign opnd_valid  = (state == HOLD);

    // Read index stops at the last word while the final data returns
    assign w_sel = (step < 4'(WEIGHTS_PER_FILTER)) ? step : 4'(WEIGHTS_PER_FILTER - 1);
    assign q_sel = (step < 4'd4) ? step[1:0] : 2'd3;
    assign q_cap = 2'(step - 4'd1);

    assign weight_addr = weight_base + weight_addr_t'(w_sel);
    assign image_addr  = quad_addr_t'(int'(quad_base) + int'(q_sel[1]) * IMG_QUADS_PER_ROW
                                      + int'(q_sel[0]));

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            step        <= '0;
            quad_base   <= '0;
            weight_base <= '0;
        end else begin
            step <= step + 1'b1;
            case (state)
                IDLE: begin
                    step <= '0;
                    if (fetch_valid) begin
                        // Top-left quad of block (i, j) is quad (i, j)
                        quad_base <= quad_addr_t'(
                            (int'(fetch_block) / BLOCKS_PER_ROW) * IMG_QUADS_PER_ROW
                            + int'(fetch_block) % BLOCKS_PER_ROW);
                        if (fetch_load_weights) begin
                            weight_base <= weight_addr_t'(int'(fetch_filter)
                                                          * WEIGHTS_PER_FILTER);
                            state       <= LOAD_W;
                        end else begin
                            state <= FETCH_B;
                        end
                    end
                end
                LOAD_W: begin
                    if (step == 4'(WEIGHTS_PER_FILTER)) begin   // Ten reads + latency
                        state <= FETCH_B;
                        step  <= '0;
                    end
                end
                FETCH_B: begin
                    if (step == 4'd4)   // Four quads + latency
                        state <= HOLD;
                end
                HOLD: begin
                    if (opnd_ready)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data lands one cycle after its address
    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_valid) begin
            filter_q  <= fetch_filter;
            post_op_q <= fetch_post_op;
        end
        if (state == LOAD_W && step != '0)
            weight_buf[step - 4'd1] <= weight_rd_data;
        if (state == FETCH_B && step != '0) begin
            for (int b = 0; b < 4; b++) begin
                // Block position {quad row, bank row, quad col, bank col}
                block_buf[{q_cap[1], 1'(b >> 1), q_cap[0], 1'(b & 1)}] <=
                    image_rd_data.bank[b];
            end
        end
    end

    assign opnd = '{block: block_buf, weights: weight_buf, filter_idx: filter_q,
                    post_op: post_op_q};

endmodule

//--- hw/conv_layer/result_writeback.sv
// Round-robin residue bank write of returning MAC results
// Completion pulse after the last result of a run
`timescale 1ns/100ps

module result_writeback (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        result_valid,
    input  conv_geom_pkg::pixel_t       result_data,
    output conv_stream_pkg::res_write_t res_write,
    output logic                        all_written
);

    import conv_geom_pkg::*;

    result_idx_t count;   // Results seen since start

    always_ff @(posedge clk) begin
        if (reset) begin
            count         <= '0;
            res_write.en  <= 1'b0;
            all_written   <= 1'b0;
        end else begin
            res_write.en <= result_valid;
            // Pulse lines up with the last write
            all_written  <= result_valid && (count == result_idx_t'(NUM_RESULTS - 1));
            if (start)
                count <= '0;
            else if (result_valid)
                count <= count + 1'b1;
        end
    end

    // Bank m mod 4, address m/4
    always_ff @(posedge clk) begin
        if (result_valid) begin
            res_write.bank <= count[1:0];
            res_write.addr <= res_addr_t'(count >> 2);
            res_write.data <= result_data;
        end
    end

endmodule

//--- hw/conv_layer/tap_emitter.sv
// Eleven-beat MAC stream per operand bundle
// Header, nine 3x3 taps over four lanes, post-op
`timescale 1ns/100ps

module tap_emitter (
    input  logic                       clk,
    input  logic                       reset,
    input  conv_stream_pkg::operand_t  opnd,
    input  logic                       opnd_valid,
    output logic                       opnd_ready,
    output conv_stream_pkg::mac_beat_t beat_out,
    output logic                       beat_valid,
    input  logic                       beat_ready
);

    import conv_geom_pkg::*;
    import conv_stream_pkg::*;

    localparam int LAST_BEAT = BEATS_PER_BLOCK - 1;

    operand_t                               opnd_q;
    logic                                   holding;
    logic [$clog2(BEATS_PER_BLOCK)-1:0]     beat_idx;
    logic                                   last_xfer;

    function automatic pixel_t block_px(input pixel_t [BLOCK_PIXELS-1:0] blk,
                                        input int row, input int col);
        return blk[row * BLOCK_DIM + col];
    endfunction

    assign beat_valid = holding;
    assign last_xfer  = holding && beat_ready && (beat_idx == LAST_BEAT);
    assign opnd_ready = !holding || last_xfer;

    always_ff @(posedge clk) begin
        if (reset) begin
            holding  <= 1'b0;
            beat_idx <= '0;
        end else if (opnd_valid && opnd_ready) begin
            holding  <= 1'b1;   // Back to back with the previous bundle
            beat_idx <= '0;
        end else if (last_xfer) begin
            holding <= 1'b0;
        end else if (holding && beat_ready) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (opnd_valid && opnd_ready)
            opnd_q <= opnd;
    end

    always_comb begin
        int tap;
        int tr;
        int tc;
        tap = int'(beat_idx) - 1;
        tr  = 0;
        tc  = 0;
        beat_out = '0;
        if (beat_idx == 0) begin
            beat_out.kind  = BEAT_HEADER;
            beat_out.param = opnd_q.weights[0];   // Bias
        end else if (beat_idx == LAST_BEAT) begin
            beat_out.kind     = BEAT_POST;
            beat_out.lane0.op = opnd_q.post_op;
            beat_out.param    = pixel_t'(opnd_q.filter_idx);
        end else begin
            tr = tap / KERNEL_DIM;
            tc = tap % KERNEL_DIM;
            // Lane n is output (n/2, n%2) of the 2x2 result
            beat_out.kind     = BEAT_TAP;
            beat_out.lane0.px = block_px(opnd_q.block, tr, tc);
            beat_out.lane1    = block_px(opnd_q.block, tr, tc + 1);
            beat_out.lane2    = block_px(opnd_q.block, tr + 1, tc);
            beat_out.lane3    = block_px(opnd_q.block, tr + 1, tc + 1);
            beat_out.param    = opnd_q.weights[tap + 1];
        end
    end

endmodule

//--- sim/conv_layer_properties.sv
// Concurrent checks on the MAC beat stream, busy/done and residue write port
`timescale 1ns/100ps

module conv_layer_properties (
    input logic                        clk,
    input logic                        reset,
    input conv_stream_pkg::mac_beat_t  beat_out,
    input logic                        beat_valid,
    input logic                        beat_ready,
    input logic                        busy,
    input logic                        done,
    input conv_stream_pkg::res_write_t res_write
);

    import conv_stream_pkg::*;

    int fail_count = 0;   // Failed assertions so far

    // Stalled beat holds until taken
    beat_stable: assert property (@(posedge clk) disable iff (reset)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat_out))
        else begin
            $error("beat changed or vanished while stalled");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        reset |=> !beat_valid && !busy && !res_write.en)
        else begin
            $error("outputs active during reset");
            fail_count++;
        end

    // done is the cycle busy drops
    done_ends_busy: assert property (@(posedge clk) disable iff (reset)
        done |-> !busy && $past(busy))
        else begin
            $error("done without busy falling");
            fail_count++;
        end

    write_known: assert property (@(posedge clk) disable iff (reset)
        res_write.en |-> !$isunknown({res_write.bank, res_write.addr, res_write.data}))
        else begin
            $error("residue write with unknown bank, address or data");
            fail_count++;
        end

endmodule

//--- sim/conv_layer_tb.sv
// Testbench for the first-layer conv sequencer
// Image and weight memory models, directed tests and compare tasks
`timescale 1ns/100ps

module conv_layer_tb;

    import conv_geom_pkg::*;
    import conv_stream_pkg::*;

    localparam int BEATS       = TAPS + 2;   // Header, nine taps, post-op
    localparam int TOTAL_BEATS = NUM_FILTERS * NUM_BLOCKS * BEATS;
    localparam int RUN_TIMEOUT = 8000;
    localparam int RESET_LIMIT = 100;

    logic         clk;
    logic         reset;
    logic         start;
    post_op_t     post_op;
    quad_addr_t   image_addr;
    quad_t        image_rd_data;
    weight_addr_t weight_addr;
    pixel_t       weight_rd_data;
    mac_beat_t    beat_out;
    logic         beat_valid;
    logic         beat_ready;
    logic         result_valid;
    pixel_t       result_data;
    res_write_t   res_write;
    logic         busy;
    logic         done;

    pixel_t      img [IMG_HEIGHT][IMG_WIDTH];
    pixel_t      wmem [NUM_FILTERS * WEIGHTS_PER_FILTER];
    logic [31:0] lcg_state = 32'd75648;

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    conv_layer_top dut (.*);

    bind conv_layer_top conv_layer_properties u_props (
        .clk        (clk),
        .reset      (reset),
        .beat_out   (beat_out),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .busy       (busy),
        .done       (done),
        .res_write  (res_write)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    // Bank (r%2)*2 + (c%2) holds pixel (r, c) at quad (r/2)*QPR + c/2
    function automatic quad_t image_quad(input quad_addr_t a);
        quad_t q;
        int    qr;
        int    qc;
        qr = int'(a) / IMG_QUADS_PER_ROW;
        qc = int'(a) % IMG_QUADS_PER_ROW;
        for (int b = 0; b < 4; b++)
            q.bank[b] = img[2 * qr + b / 2][2 * qc + b % 2];
        return q;
    endfunction

    always @(posedge clk) begin   // One cycle read latency
        image_rd_data <= image_quad(image_addr);
        if (int'(weight_addr) < NUM_FILTERS * WEIGHTS_PER_FILTER)
            weight_rd_data <= wmem[weight_addr];
        else
            weight_rd_data <= '0;
    end

    // Any bound assertion failure ends the run
    always @(negedge clk) begin
        if (dut.u_props.fail_count != 0)
            stop_with_failure("A bound assertion on the DUT failed");
    end

    // Beat n of the whole run, filters outer and blocks inner
    function automatic mac_beat_t expected_beat(input int n, input post_op_t op);
        mac_beat_t e;
        int        f;
        int        blk;
        int        b;
        int        k;
        int        r0;
        int        c0;
        f   = n / (NUM_BLOCKS * BEATS);
        blk = (n / BEATS) % NUM_BLOCKS;
        b   = n % BEATS;
        r0  = 2 * (blk / BLOCKS_PER_ROW);
        c0  = 2 * (blk % BLOCKS_PER_ROW);
        e   = '0;
        if (b == 0) begin
            e.kind  = BEAT_HEADER;
            e.param = wmem[f * WEIGHTS_PER_FILTER];   // Bias
        end else if (b == BEATS - 1) begin
            e.kind     = BEAT_POST;
            e.lane0.op = op;
            e.param    = pixel_t'(f);
        end else begin
            k          = b - 1;
            e.kind     = BEAT_TAP;
            e.lane0.px = img[r0 + k / 3][c0 + k % 3];
            e.lane1    = img[r0 + k / 3][c0 + 1 + k % 3];
            e.lane2    = img[r0 + 1 + k / 3][c0 + k % 3];
            e.lane3    = img[r0 + 1 + k / 3][c0 + 1 + k % 3];
            e.param    = wmem[f * WEIGHTS_PER_FILTER + k + 1];
        end
        return e;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_beat(input mac_beat_t got, input mac_beat_t exp, input string name);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
    endtask

    task automatic check_res_write(input res_write_t got, input res_write_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at time %0t: res_write is %h, expected %h",
                                        $time, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
            stop_with_failure($sformatf("FAILED at time %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
    endtask

    task automatic test_reset_state();
        check_bit(beat_valid, 1'b0, "beat_valid");
        check_bit(busy, 1'b0, "busy");
        check_bit(done, 1'b0, "done");
        check_bit(res_write.en, 1'b0, "res_write.en");
    endtask

    // One full layer run, results fed back as each post beat transfers
    task automatic run_layer(input post_op_t op, input logic random_ready);
        pixel_t     sent[$];
        mac_beat_t  exp_beat;
        res_write_t exp_wr;
        pixel_t     res;
        int         beats;
        int         writes;
        int         cycles;
        bit         done_seen;
        beats     = 0;
        writes    = 0;
        cycles    = 0;
        done_seen = 1'b0;
        @(negedge clk);
        start   = 1'b1;
        post_op = op;
        @(negedge clk);
        start   = 1'b0;
        post_op = ~op;   // Only the value at start counts
        check_bit(busy, 1'b1, "busy");
        while (!done_seen) begin
            if (cycles == RUN_TIMEOUT)
                stop_with_failure("Layer run did not finish within the cycle limit");
            beat_ready   = random_ready ? ((lcg_next() % 3) != 0) : 1'b1;
            result_valid = 1'b0;
            if (res_write.en) begin
                if (sent.size() == 0)
                    stop_with_failure("Residue write without a fed result");
                exp_wr = '{en: 1'b1, bank: 2'(writes % 4), addr: res_addr_t'(writes / 4),
                           data: sent.pop_front()};
                check_res_write(res_write, exp_wr);
                writes++;
            end
            if (done) begin
                if (beats != TOTAL_BEATS || writes != NUM_RESULTS)
                    stop_with_failure("done came before all beats and writes");
                check_bit(busy, 1'b0, "busy");
                done_seen = 1'b1;
            end else if (beat_valid && beat_ready) begin
                if (beats == TOTAL_BEATS)
                    stop_with_failure("Beat transferred after the end of the stream");
                exp_beat = expected_beat(beats, op);
                check_beat(beat_out, exp_beat, "beat_out");
                if (exp_beat.kind == BEAT_POST) begin
                    res          = pixel_t'(lcg_next());
                    result_valid = 1'b1;
                    result_data  = res;
                    sent.push_back(res);
                end
                beats++;
            end
            @(negedge clk);
            cycles++;
        end
        beat_ready   = 1'b0;
        result_valid = 1'b0;
    endtask

    task automatic test_stream_ready_high();
        run_layer('{maxpool: 1'b1, relu: 1'b1, shift: 6'd5}, 1'b0);
    endtask

    task automatic test_stream_random_ready();
        run_layer('{maxpool: 1'b0, relu: 1'b1, shift: 6'd12}, 1'b1);
    endtask

    task automatic test_restart_new_post_op();
        run_layer('{maxpool: 1'b1, relu: 1'b0, shift: 6'd33}, 1'b0);
    endtask

    initial begin
        int wait_cycles;
        start          = 1'b0;
        post_op        = '0;
        beat_ready     = 1'b0;
        result_valid   = 1'b0;
        result_data    = '0;
        image_rd_data  = '0;
        weight_rd_data = '0;
        for (int r = 0; r < IMG_HEIGHT; r++)
            for (int c = 0; c < IMG_WIDTH; c++)
                img[r][c] = pixel_t'(lcg_next());
        for (int i = 0; i < NUM_FILTERS * WEIGHTS_PER_FILTER; i++)
            wmem[i] = pixel_t'(lcg_next());

        wait_cycles = 0;
        @(negedge clk);
        while (reset) begin
            if (wait_cycles == RESET_LIMIT)
                stop_with_failure("Reset was never released");
            @(negedge clk);
            wait_cycles++;
        end

        test_reset_state();
        test_stream_ready_high();
        test_stream_random_ready();
        test_restart_new_post_op();
        repeat (3) @(negedge clk);

        if (dut.u_props.fail_count != 0) begin
            stop_with_failure("A bound assertion on the DUT failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam time HALF_PERIOD  = 5ns;   // 10 ns clock
    localparam int  RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // Released away from the active edge
    end

endmodule
